//--- build.f
+incdir+verilog
verilog/cachePkg.sv
verilog/cachePorts.sv
verilog/tagArray.sv
verilog/pseudoLru.sv
verilog/wayAllocator.sv
verilog/tagDirectory.sv
test/tagDirectory_checker.sv
test/tagDirectoryTb.sv

//--- test/tagDirectoryTb.sv
// Tag directory testbench: directed and random accesses against a reference model
`timescale 1ns/1ns
`default_nettype none

`include "cache_config.svh"

module tagDirectoryTb;

  localparam int ResetCycles      = 8;
  localparam int MaxRequests      = 80;
  // Drive, three edges to ack, up to three hold cycles, release and idle edge
  localparam int CyclesPerRequest = 12;
  localparam int CycleLimit       = ResetCycles + MaxRequests * CyclesPerRequest;

  logic                 clk;
  logic                 reset;
  logic                 req;
  cachePkg::cacheOp_t   op;
  cachePkg::cacheAddr_t addr;
  logic                 ack;
  logic                 hit;
  cachePkg::wayMask_t   way;
  logic                 evictValid;
  cachePkg::tag_t       evictTag;

  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;

  // Reference model state
  cachePkg::tag_t     modelTags  [`CACHE_SETS][`CACHE_WAYS];
  logic               modelValid [`CACHE_SETS][`CACHE_WAYS];
  cachePkg::lruTree_t modelTree  [`CACHE_SETS];

  tagDirectory u_dut (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .op         (op),
    .addr       (addr),
    .ack        (ack),
    .hit        (hit),
    .way        (way),
    .evictValid (evictValid),
    .evictTag   (evictTag)
  );

  always #2 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: the DUT handshake did not finish within %0d cycles", CycleLimit);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compareWay(input cachePkg::wayMask_t got, input cachePkg::wayMask_t exp,
                            input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compareTag(input cachePkg::tag_t got, input cachePkg::tag_t exp,
                            input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compareBit(input logic got, input logic exp, input string what);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Lowest free way first, else walk the tree (a one points to the upper child)
  function automatic int pickVictim(input int s);
    int victim;
    victim = -1;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (!modelValid[s][w]) victim = w;
    end
    if (victim < 0) begin
      if (!modelTree[s][2]) victim = modelTree[s][1] ? 1 : 0;
      else victim = modelTree[s][0] ? 3 : 2;
    end
    return victim;
  endfunction

  // Root and pair bit on the way's path point away from it
  task automatic touchTree(input int s, input int w);
    if (w < 2) begin
      modelTree[s][2] = 1'b1;
      modelTree[s][1] = (w == 0);
    end else begin
      modelTree[s][2] = 1'b0;
      modelTree[s][0] = (w == 2);
    end
  endtask

  task automatic modelAccess(input int s, input cachePkg::tag_t t, output logic expHit,
                             output cachePkg::wayMask_t expWay, output logic expEvict,
                             output cachePkg::tag_t expTag);
    int w;
    w = -1;
    for (int i = 0; i < `CACHE_WAYS; i++) begin
      if (modelValid[s][i] && modelTags[s][i] == t) w = i;
    end
    expHit   = (w >= 0);
    expEvict = 1'b0;
    expTag   = '0;
    if (!expHit) begin
      w        = pickVictim(s);
      expEvict = modelValid[s][w];
      expTag   = modelTags[s][w];
      modelTags[s][w]  = t;
      modelValid[s][w] = 1'b1;
    end
    expWay = cachePkg::wayMask_t'(1) << w;
    touchTree(s, w);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  // Full four-phase cycle with the response sampled on the falling edge
  task automatic doRequest(input cachePkg::cacheOp_t reqOp, input cachePkg::cacheAddr_t reqAddr,
                           input int hold, output logic gotHit, output cachePkg::wayMask_t gotWay,
                           output logic gotEvict, output cachePkg::tag_t gotTag);
    int edges;
    @(posedge clk);
    req  <= 1'b1;
    op   <= reqOp;
    addr <= reqAddr;
    edges = 0;
    do begin
      @(negedge clk);
      edges++;
    end while (!ack);
    // Capture on the first edge after driving, then three edges to ack
    checkCount++;
    if (edges != 4) begin
      errorCount++;
      $display("FAILED at %0t: ack came %0d edges after capture, expected 3", $time, edges - 1);
    end
    gotHit   = hit;
    gotWay   = way;
    gotEvict = evictValid;
    gotTag   = evictTag;
    repeat (hold) @(posedge clk);
    @(posedge clk);
    req <= 1'b0;
    do @(negedge clk); while (ack);
  endtask

  task automatic accessCheck(input cachePkg::setIndex_t s, input cachePkg::tag_t t,
                             input int hold, output cachePkg::wayMask_t seenWay);
    logic               expHit;
    logic               expEvict;
    logic               gotHit;
    logic               gotEvict;
    cachePkg::wayMask_t expWay;
    cachePkg::tag_t     expTag;
    cachePkg::tag_t     gotTag;
    modelAccess(int'(s), t, expHit, expWay, expEvict, expTag);
    doRequest(cachePkg::opAccess, {t, s}, hold, gotHit, seenWay, gotEvict, gotTag);
    compareBit(gotHit, expHit, "hit");
    compareWay(seenWay, expWay, "way");
    compareBit(gotEvict, expEvict, "evictValid");
    if (expEvict) compareTag(gotTag, expTag, "evictTag");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  // Empty set fills ways 0 to 3
  task automatic coldFillTest();
    cachePkg::wayMask_t seen;
    for (int i = 0; i < 4; i++) begin
      accessCheck(4'd0, 8'h10 + i, 0, seen);
      compareWay(seen, cachePkg::wayMask_t'(1) << i, "cold fill way");
    end
  endtask

  task automatic repeatHitTest();
    cachePkg::wayMask_t seen;
    for (int i = 0; i < 4; i++) begin
      accessCheck(4'd0, 8'h10 + i, 0, seen);
      compareWay(seen, cachePkg::wayMask_t'(1) << i, "repeat hit way");
    end
  endtask

  // Reorder with hits, then evict through the tree
  task automatic lruVictimTest();
    cachePkg::wayMask_t seen;
    accessCheck(4'd0, 8'h12, 0, seen);
    accessCheck(4'd0, 8'h10, 0, seen);
    accessCheck(4'd0, 8'h20, 0, seen);
    accessCheck(4'd0, 8'h21, 0, seen);
    accessCheck(4'd0, 8'h12, 0, seen);
    accessCheck(4'd0, 8'h22, 0, seen);
  endtask

  task automatic setIsolationTest();
    cachePkg::wayMask_t seen;
    for (int i = 0; i < 4; i++) accessCheck(4'd9, 8'h30 + i, 0, seen);
    accessCheck(4'd0, 8'h20, 0, seen);
    accessCheck(4'd9, 8'h40, 0, seen);
    accessCheck(4'd0, 8'h10, 0, seen);
    accessCheck(4'd9, 8'h31, 0, seen);
    accessCheck(4'd9, 8'h41, 0, seen);
  endtask

  task automatic invalidateTest();
    logic               gotHit;
    logic               gotEvict;
    cachePkg::wayMask_t gotWay;
    cachePkg::tag_t     gotTag;
    // Address of a resident line in a full set
    doRequest(cachePkg::opInvalidate, {8'h20, 4'd0}, 0, gotHit, gotWay, gotEvict, gotTag);
    compareBit(gotHit, 1'b0, "invalidate hit");
    compareWay(gotWay, '0, "invalidate way");
    compareBit(gotEvict, 1'b0, "invalidate evictValid");
    foreach (modelValid[s, w]) modelValid[s][w] = 1'b0;
    // Old lines are gone and refill restarts at way 0
    accessCheck(4'd0, 8'h20, 0, gotWay);
    compareWay(gotWay, 4'b0001, "refill way");
    accessCheck(4'd9, 8'h31, 0, gotWay);
    compareWay(gotWay, 4'b0001, "refill way");
  endtask

  // Small tag range over four sets gives a mix of hits and evictions
  task automatic randomAccessTest(input int count);
    cachePkg::wayMask_t  seen;
    cachePkg::setIndex_t s;
    cachePkg::tag_t      t;
    for (int i = 0; i < count; i++) begin
      s = cachePkg::setIndex_t'($urandom_range(3, 0));
      t = cachePkg::tag_t'($urandom_range(7, 0));
      accessCheck(s, t, int'($urandom_range(3, 0)), seen);
    end
  endtask

  initial begin
    void'($urandom(32'h2bd8_c71b));
    clk   = 1'b0;
    reset = 1'b1;
    req   = 1'b0;
    op    = cachePkg::opAccess;
    addr  = '0;
    foreach (modelValid[s, w]) begin
      modelValid[s][w] = 1'b0;
      modelTags[s][w]  = '0;
    end
    foreach (modelTree[s]) modelTree[s] = '0;
    repeat (ResetCycles) @(posedge clk);
    reset <= 1'b0;

    coldFillTest();
    repeatHitTest();
    lruVictimTest();
    setIsolationTest();
    invalidateTest();
    randomAccessTest(40);

    repeat (2) @(posedge clk);
    errorCount += u_dut.uChecker.violationCount;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checkCount, errorCount,
             u_dut.uChecker.violationCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tagDirectory_checker.sv
// Tag directory checker: handshake and response assertions attached by bind
`timescale 1ns/1ns
`default_nettype none

module tagDirectory_checker (
  input logic               clk,
  input logic               reset,
  input logic               req,
  input logic               ack,
  input logic               hit,
  input cachePkg::wayMask_t way
);

  // Assertion failures so far, read back by the testbench
  int violationCount = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Four-phase handshake
  ////////////////////////////////////////////////////////////////////////////

  // Directory leaves reset with ack low
  ackAfterReset: assert property (@(posedge clk) reset |=> !ack)
    else begin
      violationCount++;
      $error("ack high in the cycle after reset");
    end

  // No response without an open request
  ackNeedsReq: assert property (@(posedge clk) disable iff (reset) (!req && !ack) |=> !ack)
    else begin
      violationCount++;
      $error("ack rose while req was low");
    end

  // Response held until the requester lets go
  ackHeldByReq: assert property (@(posedge clk) disable iff (reset) (req && ack) |=> ack)
    else begin
      violationCount++;
      $error("ack fell while req was still high");
    end

  // A hit names exactly one way
  hitWayOneHot: assert property (@(posedge clk) disable iff (reset) (ack && hit) |-> $onehot(way))
    else begin
      violationCount++;
      $error("hit reported with a way mask that is not one-hot");
    end

endmodule

bind tagDirectory tagDirectory_checker uChecker (.*);

`default_nettype wire

//--- verilog/tagDirectory.sv
// Tag directory top: tag array and pseudo-LRU side by side under one controller
`timescale 1ns/1ns
`default_nettype none

module tagDirectory (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  cachePkg::cacheOp_t    op,
  input  cachePkg::cacheAddr_t  addr,
  output logic                  ack,
  output logic                  hit,
  output cachePkg::wayMask_t    way,
  output logic                  evictValid,
  output cachePkg::tag_t        evictTag
);

  // Controller to unit links
  tagPortIf tagPort ();
  lruPortIf lruPort ();

  ////////////////////////////////////////////////////////////////////////////
  // Side-by-side lookup units
  ////////////////////////////////////////////////////////////////////////////

  tagArray uTagArray (
    .clk     (clk),
    .reset   (reset),
    .tagPort (tagPort.array)
  );

  pseudoLru uPseudoLru (
    .clk     (clk),
    .reset   (reset),
    .lruPort (lruPort.tree)
  );

  // Handshake and allocation
  wayAllocator uWayAllocator (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .op         (op),
    .addr       (addr),
    .ack        (ack),
    .hit        (hit),
    .evictValid (evictValid),
    .way        (way),
    .evictTag   (evictTag),
    .tagPort    (tagPort.master),
    .lruPort    (lruPort.master)
  );

endmodule

`default_nettype wire

//--- verilog/wayAllocator.sv
// Allocation controller: four-phase handshake, hit or victim merge, write schedule
`timescale 1ns/1ns
`default_nettype none

module wayAllocator (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  cachePkg::cacheOp_t    op,
  input  cachePkg::cacheAddr_t  addr,
  output logic                  ack,
  output logic                  hit,
  output logic                  evictValid,
  output cachePkg::wayMask_t    way,
  output cachePkg::tag_t        evictTag,
  tagPortIf.master              tagPort,
  lruPortIf.master              lruPort
);

  localparam int SetBits = $bits(cachePkg::setIndex_t);
  localparam int TagBits = $bits(cachePkg::tag_t);

  cachePkg::allocState_t state;

  // Request captured on the first edge
  cachePkg::cacheOp_t   opReg;
  cachePkg::cacheAddr_t addrReg;
  cachePkg::setIndex_t  reqSet;
  cachePkg::tag_t       reqTag;
  logic                 isAccess;
  logic                 start;

  // Merged lookup results
  logic                 lookupHit;
  logic                 victimValid;
  cachePkg::tag_t       victimTag;

  assign reqSet   = addrReg[SetBits-1:0];
  assign reqTag   = addrReg[SetBits +: TagBits];
  assign isAccess = (opReg == cachePkg::opAccess);
  assign start    = (state == cachePkg::stIdle) && req;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  // Idle, read, resolve, then ack until req drops
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= cachePkg::stIdle;
      hit        <= 1'b0;
      evictValid <= 1'b0;
    end else begin
      case (state)
        cachePkg::stIdle: begin
          if (req) state <= cachePkg::stRead;
        end
        cachePkg::stRead: begin
          state      <= cachePkg::stResolve;
          hit        <= isAccess && lookupHit;
          evictValid <= isAccess && !lookupHit && victimValid;
        end
        cachePkg::stResolve: state <= cachePkg::stAck;
        // Response held while the requester keeps req high
        cachePkg::stAck: begin
          if (!req) state <= cachePkg::stIdle;
        end
        default: state <= cachePkg::stIdle;
      endcase
    end
  end

  assign ack = (state == cachePkg::stAck);

  // Request and response payload
  always_ff @(posedge clk) begin
    if (start) begin
      opReg   <= op;
      addrReg <= addr;
    end
    if (state == cachePkg::stRead) begin
      // Invalidate reports no way
      way      <= !isAccess ? '0 : (lookupHit ? tagPort.hitWay : lruPort.victimWay);
      evictTag <= victimTag;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Merge of tag and tree results
  ////////////////////////////////////////////////////////////////////////////

  assign lookupHit   = |tagPort.hitWay;
  assign victimValid = |(lruPort.victimWay & tagPort.validWay);

  // Old tag of the victim, victimWay is one-hot
  always_comb begin
    victimTag = '0;
    for (int w = 0; w < $bits(cachePkg::wayMask_t); w++) begin
      if (lruPort.victimWay[w]) victimTag = victimTag | tagPort.setTags[w];
    end
  end

  // Both reads go out on the capture edge
  assign tagPort.readEn    = start;
  assign tagPort.readSet   = addr[SetBits-1:0];
  assign tagPort.lookupTag = reqTag;
  assign lruPort.readEn    = start;
  assign lruPort.readSet   = addr[SetBits-1:0];

  // Writes commit on the edge that raises ack
  assign tagPort.writeEn  = (state == cachePkg::stResolve) && isAccess && !hit;
  assign tagPort.writeSet = reqSet;
  assign tagPort.writeWay = way;
  assign tagPort.writeTag = reqTag;
  assign tagPort.clearAll = (state == cachePkg::stResolve) && !isAccess;

  // Tree touch on every access, the tree picks hit or victim itself
  assign lruPort.updateEn  = (state == cachePkg::stResolve) && isAccess;
  assign lruPort.updateSet = reqSet;
  assign lruPort.hitWay    = tagPort.hitWay;
  assign lruPort.validWay  = tagPort.validWay;

endmodule

`default_nettype wire

//--- verilog/pseudoLru.sv
// Tree pseudo-LRU: one tree per set, victim choice and update on each access
`timescale 1ns/1ns
`default_nettype none

`include "cache_config.svh"

module pseudoLru (
  input logic    clk,
  input logic    reset,
  lruPortIf.tree lruPort
);

  localparam int Ways    = `CACHE_WAYS;
  localparam int LogWays = $clog2(`CACHE_WAYS);

  // Tree bits per set
  // Heap node h (root 1, children 2h and 2h+1) lives in bit Ways-1-h
  cachePkg::lruTree_t treeMem [`CACHE_SETS];
  cachePkg::lruTree_t treeQ;

  cachePkg::wayMask_t firstFree;
  cachePkg::wayMask_t treeWay;
  cachePkg::wayMask_t touchWay;
  logic [LogWays-1:0] touchIdx;
  logic               allValid;

  ////////////////////////////////////////////////////////////////////////////
  // Tree walks
  ////////////////////////////////////////////////////////////////////////////

  // Follow the bits from the root
  // A one means go to the upper child
  function automatic cachePkg::wayMask_t treeVictim(cachePkg::lruTree_t tree);
    int                 node;
    cachePkg::wayMask_t result;
    node = 1;
    for (int level = 0; level < LogWays; level++) begin
      node = 2 * node + int'(tree[Ways-1-node]);
    end
    result = '0;
    // Leaves are numbered Ways up to 2*Ways-1
    result[node-Ways] = 1'b1;
    return result;
  endfunction

  // Climb from the leaf and point every parent away from the way
  function automatic cachePkg::lruTree_t treeTouch(cachePkg::lruTree_t tree, int wayIdx);
    int                 node;
    cachePkg::lruTree_t result;
    result = tree;
    node   = wayIdx + Ways;
    for (int level = 0; level < LogWays; level++) begin
      // Even node is the lower child, so the parent points up
      result[Ways-1-(node>>1)] = ~node[0];
      node = node >> 1;
    end
    return result;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Victim selection
  ////////////////////////////////////////////////////////////////////////////

  assign allValid = &lruPort.validWay;
  assign treeWay  = treeVictim(treeQ);

  // Lowest numbered free way
  always_comb begin
    firstFree = '0;
    for (int w = Ways - 1; w >= 0; w--) begin
      if (!lruPort.validWay[w]) begin
        firstFree = cachePkg::wayMask_t'(1) << w;
      end
    end
  end

  // Free ways are filled before the tree is consulted
  assign lruPort.victimWay = allValid ? treeWay : firstFree;

  // Hit way when there is one, else the way being filled
  assign touchWay = (lruPort.hitWay != '0) ? lruPort.hitWay : lruPort.victimWay;

  always_comb begin
    touchIdx = '0;
    for (int w = 0; w < Ways; w++) begin
      if (touchWay[w]) begin
        touchIdx = LogWays'(w);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // All trees start at zero
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        treeMem[s] <= '0;
      end
      treeQ <= '0;
    end else begin
      if (lruPort.updateEn) begin
        // treeQ still holds the tree of the set being updated
        treeMem[lruPort.updateSet] <= treeTouch(treeQ, int'(touchIdx));
      end
      if (lruPort.readEn) begin
        treeQ <= treeMem[lruPort.readSet];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/tagArray.sv
// Tag array: per-set tags and valid bits, synchronous set read and tag compare
`timescale 1ns/1ns
`default_nettype none

`include "cache_config.svh"

module tagArray (
  input logic     clk,
  input logic     reset,
  tagPortIf.array tagPort
);

  // Tag storage, one vector of all ways per set
  cachePkg::tagVector_t tagMem [`CACHE_SETS];
  // Valid flags kept in flops so they can be cleared at once
  cachePkg::wayMask_t   validBits [`CACHE_SETS];

  // Set read registers
  cachePkg::tagVector_t tagsQ;
  cachePkg::wayMask_t   validQ;

  // Compare result
  cachePkg::wayMask_t   matchWay;

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Tag write, only the selected way of the set changes
  always_ff @(posedge clk) begin
    if (tagPort.writeEn) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        if (tagPort.writeWay[w]) begin
          tagMem[tagPort.writeSet][w] <= tagPort.writeTag;
        end
      end
    end
  end

  // Valid bits
  // Invalidate wins over a write in the same cycle
  always_ff @(posedge clk) begin
    if (reset || tagPort.clearAll) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        validBits[s] <= '0;
      end
    end else if (tagPort.writeEn) begin
      validBits[tagPort.writeSet] <= validBits[tagPort.writeSet] | tagPort.writeWay;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Set read
  ////////////////////////////////////////////////////////////////////////////

  // Tags of the set, held until the next read
  always_ff @(posedge clk) begin
    if (tagPort.readEn) begin
      tagsQ <= tagMem[tagPort.readSet];
    end
  end

  // Valid mask of the set
  always_ff @(posedge clk) begin
    if (reset) begin
      validQ <= '0;
    end else if (tagPort.readEn) begin
      validQ <= validBits[tagPort.readSet];
    end
  end

  // Hit per way: valid and tag equal
  always_comb begin
    matchWay = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      matchWay[w] = validQ[w] && (tagsQ[w] == tagPort.lookupTag);
    end
  end

  // Results back to the controller
  assign tagPort.hitWay   = matchWay;
  assign tagPort.validWay = validQ;
  assign tagPort.setTags  = tagsQ;

endmodule

`default_nettype wire

//--- verilog/cachePorts.sv
// Interfaces between the allocation controller and the tag and LRU units
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Tag array port
////////////////////////////////////////////////////////////////////////////

interface tagPortIf;
  // Read side
  logic                   readEn;
  cachePkg::setIndex_t    readSet;
  cachePkg::tag_t         lookupTag;
  cachePkg::wayMask_t     hitWay;
  cachePkg::wayMask_t     validWay;
  cachePkg::tagVector_t   setTags;
  // Write side, writeWay is one-hot
  logic                   writeEn;
  cachePkg::setIndex_t    writeSet;
  cachePkg::wayMask_t     writeWay;
  cachePkg::tag_t         writeTag;
  logic                   clearAll;

  modport master (output readEn, readSet, lookupTag, writeEn, writeSet, writeWay,
                  writeTag, clearAll, input hitWay, validWay, setTags);
  modport array (input readEn, readSet, lookupTag, writeEn, writeSet, writeWay,
                 writeTag, clearAll, output hitWay, validWay, setTags);
endinterface

////////////////////////////////////////////////////////////////////////////
// Replacement tree port
////////////////////////////////////////////////////////////////////////////

interface lruPortIf;
  logic                   readEn;
  cachePkg::setIndex_t    readSet;
  logic                   updateEn;
  cachePkg::setIndex_t    updateSet;
  // Relayed from the tag array
  cachePkg::wayMask_t     hitWay;
  cachePkg::wayMask_t     validWay;
  cachePkg::wayMask_t     victimWay;

  modport master (output readEn, readSet, updateEn, updateSet, hitWay, validWay,
                  input victimWay);
  modport tree (input readEn, readSet, updateEn, updateSet, hitWay, validWay,
                output victimWay);
endinterface

`default_nettype wire

//--- verilog/cachePkg.sv
// Shared types of the tag directory: opcodes, controller states and vectors
`default_nettype none

`include "cache_config.svh"

package cachePkg;

  // Requester opcodes
  typedef enum logic {
    opAccess,
    opInvalidate
  } cacheOp_t;

  // Allocation controller states, one per handshake phase
  typedef enum logic [1:0] {
    stIdle,
    stRead,
    stResolve,
    stAck
  } allocState_t;

  // One bit per way, used for one-hot way selects and valid masks
  typedef logic [`CACHE_WAYS-1:0] wayMask_t;
  typedef logic [$clog2(`CACHE_SETS)-1:0] setIndex_t;
  typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
  // Tag sits above the set index
  typedef logic [`CACHE_TAG_BITS+$clog2(`CACHE_SETS)-1:0] cacheAddr_t;
  // Binary tree has one node fewer than the way count
  typedef logic [`CACHE_WAYS-2:0] lruTree_t;
  typedef tag_t [`CACHE_WAYS-1:0] tagVector_t;

endpackage

`default_nettype wire

//--- verilog/cache_config.svh
// Geometry of the tag directory: ways per set, set count and tag width
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Directory geometry
////////////////////////////////////////////////////////////////////////////

// Ways per set, any power of two from 2 up
`define CACHE_WAYS 4

// Sets in the directory, power of two
`define CACHE_SETS 16

// Tag bits above the set index in a request address
`define CACHE_TAG_BITS 8

`endif
